// File: run_sim.sh
#!/bin/sh
# Builds the core assist testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -f tb.f --top-module tb_cluster_core_assist -o tb_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }

// File: source/cluster_core_assist.sv
/*
 * Data-side assist block of one cluster core. Connects the core bus to
 * the TCDM, event unit and DMA ports and exports the performance strobes.
 */

`timescale 1ns/1ps

module cluster_core_assist (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  cluster_map_pkg::cluster_id_t cluster_id_i,
  input  core_bus_pkg::bus_req_t       core_req_i,
  output logic                         core_gnt_o,
  output core_bus_pkg::bus_rsp_t       core_rsp_o,
  output core_bus_pkg::bus_req_t       tcdm_req_o,
  input  logic                         tcdm_gnt_i,
  input  core_bus_pkg::bus_rsp_t       tcdm_rsp_i,
  output core_bus_pkg::bus_req_t       eu_req_o,
  input  logic                         eu_gnt_i,
  input  core_bus_pkg::bus_rsp_t       eu_rsp_i,
  output core_bus_pkg::bus_req_t       dma_req_o,
  input  logic                         dma_gnt_i,
  input  core_bus_pkg::bus_rsp_t       dma_rsp_i,
  output logic [2:0]                   perf_counters_o
);

  import core_bus_pkg::*;

  logic     issue_en;
  logic     tcdm_hit;
  logic     tcdm_gnt;
  logic     periph_hit;
  logic     periph_gnt;
  bus_rsp_t periph_rsp;

  // Strobe order is contention, peripheral load, peripheral store
  tcdm_port i_tcdm_port (
    .core_req_i        (core_req_i),
    .cluster_id_i      (cluster_id_i),
    .issue_en_i        (issue_en),
    .hit_o             (tcdm_hit),
    .gnt_o             (tcdm_gnt),
    .tcdm_req_o        (tcdm_req_o),
    .tcdm_gnt_i        (tcdm_gnt_i),
    .perf_contention_o (perf_counters_o[0])
  );

  periph_demux i_periph_demux (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .core_req_i   (core_req_i),
    .cluster_id_i (cluster_id_i),
    .issue_en_i   (issue_en),
    .hit_o        (periph_hit),
    .gnt_o        (periph_gnt),
    .rsp_o        (periph_rsp),
    .eu_req_o     (eu_req_o),
    .eu_gnt_i     (eu_gnt_i),
    .eu_rsp_i     (eu_rsp_i),
    .dma_req_o    (dma_req_o),
    .dma_gnt_i    (dma_gnt_i),
    .dma_rsp_i    (dma_rsp_i),
    .perf_ld_o    (perf_counters_o[1]),
    .perf_st_o    (perf_counters_o[2])
  );

  core_resp_merge i_core_resp_merge (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .core_req_i   (core_req_i),
    .tcdm_hit_i   (tcdm_hit),
    .tcdm_gnt_i   (tcdm_gnt),
    .tcdm_rsp_i   (tcdm_rsp_i),
    .periph_hit_i (periph_hit),
    .periph_gnt_i (periph_gnt),
    .periph_rsp_i (periph_rsp),
    .issue_en_o   (issue_en),
    .core_gnt_o   (core_gnt_o),
    .core_rsp_o   (core_rsp_o)
  );

endmodule

// File: source/cluster_map_pkg.sv
/*
 * Cluster address map and the target encoding used to steer accesses.
 * Windows are identified by the top address bits above the TCDM offset.
 */

package cluster_map_pkg;

  localparam int unsigned TCDM_SIZE_BITS   = 22;
  localparam int unsigned PERIPH_SIZE_BITS = 12;

  typedef logic [31-TCDM_SIZE_BITS:0] region_t;
  typedef logic [5:0]                 cluster_id_t;

  // Top bits of the alias window and of the first cluster
  localparam region_t TCDM_ALIAS_BASE = 10'h000;
  localparam region_t CLUSTER_BASE    = 10'h040;

  // Peripheral window sits above the TCDM inside the cluster range
  localparam logic [TCDM_SIZE_BITS-1:0] PERIPH_OFFSET = 22'h20_0000;

  // Offset bit 11 picks the peripheral target
  localparam logic EU_SEL  = 1'b0;
  localparam logic DMA_SEL = 1'b1;

  typedef enum logic [1:0] {
    TGT_NONE = 2'd0,
    TGT_TCDM = 2'd1,
    TGT_EU   = 2'd2,
    TGT_DMA  = 2'd3
  } target_e;

  // Each cluster owns four windows worth of top bits
  function automatic region_t cluster_region(input cluster_id_t id);
    return CLUSTER_BASE + region_t'({id, 2'b00});
  endfunction

endpackage

// File: source/core_bus_pkg.sv
/*
 * Core data bus definitions shared by every block of the core assist.
 * Request and response bundles travel between modules as packed structs.
 */

package core_bus_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // Deepest run of accesses to one target that may be in flight
  localparam int unsigned MAX_OUTSTANDING = 7;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;
  typedef logic [2:0]            outst_cnt_t;

  // Address phase, held stable while req is high until gnt
  typedef struct packed {
    logic  req;
    logic  wen;
    addr_t add;
    data_t wdata;
    be_t   be;
  } bus_req_t;

  // Response phase, one r_valid cycle per granted access
  typedef struct packed {
    logic  r_valid;
    logic  r_opc;
    data_t r_rdata;
  } bus_rsp_t;

endpackage

// File: source/core_resp_merge.sv
/*
 * Response merger of the core assist. Picks the grant of the claiming
 * path, holds back requests to a new target until the old one has drained,
 * answers unmapped accesses with an error and routes responses to the core.
 */

`timescale 1ns/1ps

module core_resp_merge (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  core_bus_pkg::bus_req_t core_req_i,
  input  logic                   tcdm_hit_i,
  input  logic                   tcdm_gnt_i,
  input  core_bus_pkg::bus_rsp_t tcdm_rsp_i,
  input  logic                   periph_hit_i,
  input  logic                   periph_gnt_i,
  input  core_bus_pkg::bus_rsp_t periph_rsp_i,
  output logic                   issue_en_o,
  output logic                   core_gnt_o,
  output core_bus_pkg::bus_rsp_t core_rsp_o
);

  import core_bus_pkg::*;
  import cluster_map_pkg::*;

  target_e    req_tgt;
  target_e    cur_tgt;
  outst_cnt_t out_cnt;
  logic       err_pend;
  logic       none_gnt;
  logic       rsp_done;

  always_comb begin
    if (tcdm_hit_i) begin
      req_tgt = TGT_TCDM;
    end else if (periph_hit_i) begin
      if (core_req_i.add[PERIPH_SIZE_BITS-1] == DMA_SEL) begin
        req_tgt = TGT_DMA;
      end else begin
        req_tgt = TGT_EU;
      end
    end else begin
      req_tgt = TGT_NONE;
    end
  end

  // Responses stay in order as long as only one target has any in flight
  assign issue_en_o = (out_cnt != outst_cnt_t'(MAX_OUTSTANDING)) &&
                      ((out_cnt == '0) || (req_tgt == cur_tgt));

  assign none_gnt = core_req_i.req & issue_en_o & (req_tgt == TGT_NONE);

  always_comb begin
    case (req_tgt)
      TGT_TCDM:        core_gnt_o = tcdm_gnt_i;
      TGT_EU, TGT_DMA: core_gnt_o = periph_gnt_i;
      default:         core_gnt_o = none_gnt;
    endcase
  end

  always_comb begin
    case (cur_tgt)
      TGT_TCDM:        core_rsp_o = tcdm_rsp_i;
      TGT_EU, TGT_DMA: core_rsp_o = periph_rsp_i;
      default: begin
        // Unmapped access, error flag with zero data
        core_rsp_o         = '0;
        core_rsp_o.r_valid = err_pend;
        core_rsp_o.r_opc   = err_pend;
      end
    endcase
  end

  assign rsp_done = core_rsp_o.r_valid;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cur_tgt  <= TGT_NONE;
      out_cnt  <= '0;
      err_pend <= 1'b0;
    end else begin
      // Error answers come exactly one cycle after their grant
      err_pend <= none_gnt;
      if (core_gnt_o) begin
        cur_tgt <= req_tgt;
      end
      if (core_gnt_o && !rsp_done) begin
        out_cnt <= out_cnt + 1'b1;
      end else if (!core_gnt_o && rsp_done) begin
        out_cnt <= out_cnt - 1'b1;
      end
    end
  end

endmodule

// File: source/periph_demux.sv
/*
 * Peripheral path of the core assist. Claims this cluster's peripheral
 * window, splits it between event unit and DMA, and merges their grants
 * and responses into one channel for the response merger.
 */

`timescale 1ns/1ps

module periph_demux (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  core_bus_pkg::bus_req_t       core_req_i,
  input  cluster_map_pkg::cluster_id_t cluster_id_i,
  input  logic                         issue_en_i,
  output logic                         hit_o,
  output logic                         gnt_o,
  output core_bus_pkg::bus_rsp_t       rsp_o,
  output core_bus_pkg::bus_req_t       eu_req_o,
  input  logic                         eu_gnt_i,
  input  core_bus_pkg::bus_rsp_t       eu_rsp_i,
  output core_bus_pkg::bus_req_t       dma_req_o,
  input  logic                         dma_gnt_i,
  input  core_bus_pkg::bus_rsp_t       dma_rsp_i,
  output logic                         perf_ld_o,
  output logic                         perf_st_o
);

  import core_bus_pkg::*;
  import cluster_map_pkg::*;

  region_t region;
  logic    fwd;
  logic    to_eu;
  logic    to_dma;
  logic    last_dma;

  assign region = core_req_i.add[ADDR_WIDTH-1:TCDM_SIZE_BITS];

  // Only the cluster's own window, the alias does not cover peripherals
  assign hit_o = (region == cluster_region(cluster_id_i)) &&
                 (core_req_i.add[TCDM_SIZE_BITS-1:PERIPH_SIZE_BITS] ==
                  PERIPH_OFFSET[TCDM_SIZE_BITS-1:PERIPH_SIZE_BITS]);

  assign to_eu  = (core_req_i.add[PERIPH_SIZE_BITS-1] == EU_SEL);
  assign to_dma = (core_req_i.add[PERIPH_SIZE_BITS-1] == DMA_SEL);
  assign fwd    = core_req_i.req & hit_o & issue_en_i;

  always_comb begin
    eu_req_o      = core_req_i;
    eu_req_o.req  = fwd & to_eu;
    dma_req_o     = core_req_i;
    dma_req_o.req = fwd & to_dma;
  end

  assign gnt_o = (eu_req_o.req & eu_gnt_i) | (dma_req_o.req & dma_gnt_i);

  // wen high marks a load
  assign perf_ld_o = gnt_o & core_req_i.wen;
  assign perf_st_o = gnt_o & ~core_req_i.wen;

  // The merger never mixes EU and DMA accesses in flight, so the target
  // of the latest grant is the one that answers next
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_dma <= 1'b0;
    end else if (gnt_o) begin
      last_dma <= to_dma;
    end
  end

  assign rsp_o = last_dma ? dma_rsp_i : eu_rsp_i;

endmodule

// File: source/tcdm_port.sv
/*
 * TCDM path of the core assist. Claims the cluster TCDM and its alias,
 * rewrites alias addresses and forwards the request to the shared memory.
 */

`timescale 1ns/1ps

module tcdm_port (
  input  core_bus_pkg::bus_req_t       core_req_i,
  input  cluster_map_pkg::cluster_id_t cluster_id_i,
  input  logic                         issue_en_i,
  output logic                         hit_o,
  output logic                         gnt_o,
  output core_bus_pkg::bus_req_t       tcdm_req_o,
  input  logic                         tcdm_gnt_i,
  output logic                         perf_contention_o
);

  import core_bus_pkg::*;
  import cluster_map_pkg::*;

  region_t                   region;
  region_t                   own_region;
  logic [TCDM_SIZE_BITS-1:0] offset;

  assign region     = core_req_i.add[ADDR_WIDTH-1:TCDM_SIZE_BITS];
  assign offset     = core_req_i.add[TCDM_SIZE_BITS-1:0];
  assign own_region = cluster_region(cluster_id_i);

  // The memory ends where the peripheral window starts
  assign hit_o = ((region == TCDM_ALIAS_BASE) || (region == own_region)) &&
                 (offset < PERIPH_OFFSET);

  always_comb begin
    tcdm_req_o     = core_req_i;
    tcdm_req_o.req = core_req_i.req & hit_o & issue_en_i;
    // Alias hits are moved to this cluster so the memory sees one map
    tcdm_req_o.add = {own_region, offset};
  end

  assign gnt_o             = tcdm_req_o.req & tcdm_gnt_i;
  assign perf_contention_o = tcdm_req_o.req & ~tcdm_gnt_i;

endmodule

// File: tb.f
source/core_bus_pkg.sv
source/cluster_map_pkg.sv
source/tcdm_port.sv
source/periph_demux.sv
source/core_resp_merge.sv
source/cluster_core_assist.sv
verif/cluster_core_assist_sva.sv
verif/tb_cluster_core_assist.sv

// File: verif/cluster_core_assist_sva.sv
/*
 * Assertions on the grant, ordering and strobe rules of the core assist.
 * Bound to the DUT from the testbench.
 */

`timescale 1ns/1ps

module cluster_core_assist_sva (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input core_bus_pkg::bus_req_t core_req_i,
  input logic                   core_gnt_o,
  input core_bus_pkg::bus_rsp_t core_rsp_o,
  input core_bus_pkg::bus_req_t tcdm_req_o,
  input core_bus_pkg::bus_req_t eu_req_o,
  input core_bus_pkg::bus_req_t dma_req_o,
  input logic [2:0]             perf_counters_o
);

  logic [2:0] route;
  logic [2:0] last_route;
  logic [3:0] in_flight;

  // An unmapped access shows up as no target at all
  assign route = {dma_req_o.req, eu_req_o.req, tcdm_req_o.req};

  // Shadow count of accesses granted but not yet answered
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_flight  <= '0;
      last_route <= '0;
    end else begin
      if (core_gnt_o) begin
        last_route <= route;
      end
      in_flight <= in_flight + 4'(core_gnt_o) - 4'(core_rsp_o.r_valid);
    end
  end

  a_gnt_same_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_gnt_o && (in_flight != 4'd0) |-> route == last_route)
    else $error("core grant to a new target while responses are outstanding");

  a_strobes_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !core_req_i.req |-> perf_counters_o == 3'b000)
    else $error("perf strobe high without a core request");

  // Unmapped accesses are answered by the merger in the following cycle
  a_unmapped_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_gnt_o && (route == 3'b000) |=>
      core_rsp_o.r_valid && core_rsp_o.r_opc && (core_rsp_o.r_rdata == '0))
    else $error("unmapped access not answered with an error in the next cycle");

endmodule

// File: verif/core_assist_tests.txt
# op (1 store, 0 load), address, write data, byte enables, expected read data, expected error
# Cluster 1: TCDM 1100_0000, alias 0000_0000, event unit 1120_0000, DMA 1120_0800
1 11000010 a1b2c3d4 f 00000000 0
1 11000010 55667788 6 00000000 0
0 11000010 00000000 f a16677d4 0
0 00000010 00000000 f a16677d4 0
1 11200004 00001111 f 00000000 0
1 11200804 22220000 f 00000000 0
0 11200004 00000000 f 00001111 0
0 11200804 00000000 f 22220000 0
0 80000000 00000000 f 00000000 1
1 00200000 12345678 f 00000000 1
0 11400000 00000000 f 00000000 1
0 11201000 00000000 f 00000000 1
1 11000100 deadbeef f 00000000 0
1 11200010 cafef00d f 00000000 0
0 11000100 00000000 f deadbeef 0
0 11200010 00000000 f cafef00d 0
1 11200810 12345678 3 00000000 0
0 00000100 00000000 f deadbeef 0
0 11200810 00000000 f 00005678 0
1 11000104 0badc0de c 00000000 0
0 11000104 00000000 f 0bad0000 0
0 90000000 00000000 f 00000000 1
0 11200004 00000000 f 00001111 0
0 11000010 00000000 f a16677d4 0

// File: verif/tb_cluster_core_assist.sv
/*
 * Testbench for the core assist. Models the TCDM, event unit and DMA
 * targets with random delays, replays the accesses of the test file and
 * checks every response, the routing of each grant and the perf strobes.
 */

`timescale 1ns/1ps

module tb_cluster_core_assist;

  import core_bus_pkg::*;

  localparam logic [5:0] CLUSTER_ID = 6'd1;
  // Cluster 1 sits four windows above the cluster base 0x040
  localparam logic [9:0] OWN_TOP = 10'h044;
  localparam int TIMEOUT_CYCLES = 100;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic [5:0]  cluster_id_i;
  bus_req_t    core_req_i;
  logic        core_gnt_o;
  bus_rsp_t    core_rsp_o;
  logic [2:0]  perf_counters_o;

  // Target index 0 is the TCDM, 1 the event unit, 2 the DMA
  bus_req_t    tgt_req [3];
  logic [2:0]  tgt_gnt = '0;
  bus_rsp_t    tgt_rsp [3] = '{default: '0};

  logic [31:0] lfsr_state = 32'h1549_5c21;
  data_t       mem [logic [31:0]];
  int          due_q [3][$];
  data_t       rdata_q [3][$];
  int          last_due [3] = '{default: 0};
  int          wait_cnt [3] = '{default: 0};
  int          cycle = 0;
  data_t       exp_rdata_q [$];
  logic        exp_err_q [$];
  // Counters in strobe order: contention, peripheral load, peripheral store
  int          exp_cnt [3] = '{default: 0};
  int          dut_cnt [3] = '{default: 0};

  assign cluster_id_i = CLUSTER_ID;

  always #5 clk_i = ~clk_i;

  cluster_core_assist i_dut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cluster_id_i    (cluster_id_i),
    .core_req_i      (core_req_i),
    .core_gnt_o      (core_gnt_o),
    .core_rsp_o      (core_rsp_o),
    .tcdm_req_o      (tgt_req[0]),
    .tcdm_gnt_i      (tgt_gnt[0]),
    .tcdm_rsp_i      (tgt_rsp[0]),
    .eu_req_o        (tgt_req[1]),
    .eu_gnt_i        (tgt_gnt[1]),
    .eu_rsp_i        (tgt_rsp[1]),
    .dma_req_o       (tgt_req[2]),
    .dma_gnt_i       (tgt_gnt[2]),
    .dma_rsp_i       (tgt_rsp[2]),
    .perf_counters_o (perf_counters_o)
  );

  bind cluster_core_assist cluster_core_assist_sva i_sva (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .core_req_i      (core_req_i),
    .core_gnt_o      (core_gnt_o),
    .core_rsp_o      (core_rsp_o),
    .tcdm_req_o      (tcdm_req_o),
    .eu_req_o        (eu_req_o),
    .dma_req_o       (dma_req_o),
    .perf_counters_o (perf_counters_o)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
  function automatic int unsigned random_bits(input int n);
    int unsigned v;
    logic        fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // One-hot target of an address: bit 0 TCDM, bit 1 event unit, bit 2 DMA
  function automatic logic [2:0] expected_route(input addr_t a);
    if ((a[31:22] == 10'h000 || a[31:22] == OWN_TOP) && a[21:0] < 22'h20_0000) begin
      return 3'b001;
    end
    if (a[31:22] == OWN_TOP && a[21:12] == 10'h200) begin
      return a[11] ? 3'b100 : 3'b010;
    end
    return 3'b000;
  endfunction

  // Performs a granted access on a target model and queues its response
  task automatic accept_access(input int t, input bus_req_t r);
    logic [31:0] key;
    data_t       word;
    int          due;
    // Event unit and DMA share offsets, so a misrouted access reads wrong data
    key = (t == 0) ? {2'd0, r.add[31:2]} : {2'(t), 21'd0, r.add[10:2]};
    word = mem.exists(key) ? mem[key] : '0;
    if (!r.wen) begin
      for (int b = 0; b < 4; b++) begin
        if (r.be[b]) begin
          word[8*b +: 8] = r.wdata[8*b +: 8];
        end
      end
      mem[key] = word;
      word = '0;
    end
    due = cycle + int'(random_bits(1));
    if (due <= last_due[t]) begin
      due = last_due[t] + 1;
    end
    last_due[t] = due;
    due_q[t].push_back(due);
    rdata_q[t].push_back(word);
    if (t > 0 && r.wen) begin
      exp_cnt[1]++;
    end else if (t > 0) begin
      exp_cnt[2]++;
    end
  endtask

  // Target models: grant after a random wait, answer 1 to 2 cycles later
  always @(posedge clk_i) begin
    cycle++;
    if (!rst_n_i) begin
      tgt_gnt <= '0;
      for (int t = 0; t < 3; t++) begin
        tgt_rsp[t] <= '0;
      end
    end else begin
      for (int t = 0; t < 3; t++) begin
        if (tgt_req[t].req && tgt_gnt[t]) begin
          accept_access(t, tgt_req[t]);
          wait_cnt[t] = int'(random_bits(2));
        end else if (tgt_req[t].req) begin
          if (t == 0) begin
            exp_cnt[0]++;
          end
          if (wait_cnt[t] > 0) begin
            wait_cnt[t]--;
          end
        end
        tgt_gnt[t] <= (wait_cnt[t] == 0);
        if (due_q[t].size() > 0 && due_q[t][0] == cycle) begin
          void'(due_q[t].pop_front());
          tgt_rsp[t] <= '{r_valid: 1'b1, r_opc: 1'b0, r_rdata: rdata_q[t].pop_front()};
        end else begin
          tgt_rsp[t] <= '0;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      for (int k = 0; k < 3; k++) begin
        if (perf_counters_o[k]) begin
          dut_cnt[k]++;
        end
      end
    end
  end

  // Responses must come back in issue order
  always @(posedge clk_i) begin
    if (rst_n_i && core_rsp_o.r_valid) begin
      if (exp_rdata_q.size() == 0) begin
        stop_run("a response arrived with no access pending");
      end
      check_value(core_rsp_o.r_rdata, exp_rdata_q.pop_front(), "read data");
      check_value(32'(core_rsp_o.r_opc), 32'(exp_err_q.pop_front()), "error flag");
    end
  end

  initial begin
    int          fd;
    int          n_fields;
    int          waited;
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] be;
    logic [31:0] exp_rdata;
    logic [31:0] exp_err;
    logic [2:0]  route;
    bus_req_t    next_req;
    rst_n_i = 1'b0;
    core_req_i = '0;
    fd = $fopen("verif/core_assist_tests.txt", "r");
    if (fd == 0) begin
      stop_run("the test file verif/core_assist_tests.txt could not be opened");
    end
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n_fields = $sscanf(line, "%h %h %h %h %h %h", op, addr, wdata, be, exp_rdata, exp_err);
      if (n_fields != 6) begin
        stop_run({"the test file has a malformed line: ", line});
      end
      next_req.req = 1'b1;
      next_req.wen = ~op[0];
      next_req.add = addr;
      next_req.wdata = wdata;
      next_req.be = be[3:0];
      core_req_i <= next_req;
      exp_rdata_q.push_back(exp_rdata);
      exp_err_q.push_back(exp_err[0]);
      waited = 0;
      do begin
        @(posedge clk_i);
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          stop_run($sformatf("no core grant for the access to %h", addr));
        end
      end while (!core_gnt_o);
      // Only the expected target may see the request, with alias removed
      route = expected_route(addr);
      check_value(32'({tgt_req[2].req, tgt_req[1].req, tgt_req[0].req}), 32'(route),
                  "target routing");
      if (route == 3'b001) begin
        check_value(tgt_req[0].add, {OWN_TOP, addr[21:0]}, "TCDM address");
      end
    end
    core_req_i <= '0;
    waited = 0;
    while (exp_rdata_q.size() > 0) begin
      @(posedge clk_i);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_run("responses still missing after the last access");
      end
    end
    check_value(dut_cnt[0], exp_cnt[0], "TCDM contention count");
    check_value(dut_cnt[1], exp_cnt[1], "peripheral load count");
    check_value(dut_cnt[2], exp_cnt[2], "peripheral store count");
    $display("TB PASSED");
    $finish;
  end

endmodule
